/* build.f */
src/cpu16_pkg.sv
src/reg_file.sv
src/fwd_unit.sv
src/id_exe.sv
src/alu_exe.sv
src/exe_core.sv
sim/tb_exe_core.sv

/* sim/exe_input.txt */
// name hold in_valid instr pc | reg_we reg_addr reg_value mem_read mem_write mem_addr mem_wdata br_taken br_target
// name: 1 arith, 2 logic, 3 shift, 4 fwd, 5 mem, 6 branch, 7 hold, 8 nop
01 0 1 6905 0010 1 1 0005 0 0 0000 0000 0 0000 // LI r1,05
01 0 1 6AF0 0011 1 2 00F0 0 0 0000 0000 0 0000 // LI r2,F0
01 0 1 497F 0012 1 1 0084 0 0 0000 0000 0 0000 // ADDIU r1,+7F
01 0 1 4AF0 0013 1 2 00E0 0 0 0000 0000 0 0000 // ADDIU r2,-10
01 0 1 E14D 0014 1 3 0164 0 0 0000 0000 0 0000 // ADDU r3=r1+r2
01 0 1 E233 0015 1 4 005C 0 0 0000 0000 0 0000 // SUBU r4=r2-r1
01 0 1 E157 0016 1 5 FFA4 0 0 0000 0000 0 0000 // SUBU r5=r1-r2
02 0 1 EBAC 0017 1 3 0124 0 0 0000 0000 0 0000 // AND r3,r5
02 0 1 EC6D 0018 1 4 017C 0 0 0000 0000 0 0000 // OR r4,r3
02 0 1 E92A 0019 1 1 0000 0 0 0000 0000 0 0000 // CMP r1,r1
02 0 1 EA8A 001A 1 2 0001 0 0 0000 0000 0 0000 // CMP r2,r4
03 0 1 36A0 001B 1 6 A400 0 0 0000 0000 0 0000 // SLL r6,r5,8
03 0 1 37CF 001C 1 7 F480 0 0 0000 0000 0 0000 // SRA r7,r6,3
03 0 1 31C2 001D 1 1 00A4 0 0 0000 0000 0 0000 // SRL r1,r6,8
04 0 1 7AE0 001E 1 2 F480 0 0 0000 0000 0 0000 // MOVE r2,r7
04 0 1 E229 001F 1 2 F524 0 0 0000 0000 0 0000 // ADDU r2=r2+r1
04 0 1 4A01 0020 1 2 F525 0 0 0000 0000 0 0000 // ADDIU r2,+1
07 1 1 6A33 0021 0 0 0000 0 0 0000 0000 0 0000 // LI r2 under hold
07 0 0 6A44 0022 0 0 0000 0 0 0000 0000 0 0000 // LI r2 not valid
05 0 1 9A1E 0023 0 0 0000 1 0 F523 0000 0 0000 // LW r2,-2
05 0 1 DCE5 0024 0 0 0000 0 1 0181 F480 0 0000 // SW r4,+5,r7
06 0 1 17FC 0025 0 0 0000 0 0 0000 0000 1 0022 // B -4
06 0 1 2010 0026 0 0 0000 0 0 0000 0000 1 0037 // BEQZ r0,+10
06 0 1 2AFF 0027 0 0 0000 0 0 0000 0000 1 0027 // BNEZ r2,-1
06 0 1 2305 0028 0 0 0000 0 0 0000 0000 0 002E // BEQZ r3,+5
04 0 1 6D00 0029 1 5 0000 0 0 0000 0000 0 0000 // LI r5,00
04 0 1 2D03 002A 0 0 0000 0 0 0000 0000 0 002E // BNEZ r5,+3
08 0 1 0800 002B 0 0 0000 0 0 0000 0000 0 0000 // NOP

/* sim/tb_exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exe_core import cpu16_pkg::*; ();

	localparam int n_vec       = 28;   // Lines in the vector file
	localparam int n_col       = 14;   // Fields per line
	localparam int rand_n      = 48;   // Random stress cycles
	localparam int cycle_limit = n_vec + rand_n + 20;

	typedef struct packed {
		logic [7:0]        name;
		logic              valid;
		logic              reg_we;
		logic [reg_aw-1:0] reg_addr;
		logic [word_w-1:0] reg_value;
		logic              mem_read;
		logic              mem_write;
		logic [word_w-1:0] mem_addr;
		logic [word_w-1:0] mem_wdata;
		logic              br_taken;
		logic [word_w-1:0] br_target;
	} expect_t;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	logic              hold;
	logic [word_w-1:0] instr;
	logic [word_w-1:0] pc;
	logic              out_valid;
	logic              reg_we;
	logic [reg_aw-1:0] reg_addr;
	logic [word_w-1:0] reg_value;
	logic              mem_read;
	logic              mem_write;
	logic [word_w-1:0] mem_addr;
	logic [word_w-1:0] mem_wdata;
	logic              br_taken;
	logic [word_w-1:0] br_target;

	logic [word_w-1:0] vec_mem [0:n_vec*n_col-1];
	logic [word_w-1:0] model [reg_num];   // Architectural register state
	expect_t           exp_q [$];
	int                checks = 0;
	int                errors = 0;
	int                cycles = 0;

	exe_core UUT (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .hold(hold),
		.instr(instr), .pc(pc),
		.out_valid(out_valid), .reg_we(reg_we),
		.reg_addr(reg_addr), .reg_value(reg_value),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.br_taken(br_taken), .br_target(br_target)
	);

	always #20 clk = ~clk;  // 40 ns period

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic string test_name(input logic [7:0] idx);
		case (idx)
			8'd0:    return "reset";
			8'd1:    return "arith";
			8'd2:    return "logic";
			8'd3:    return "shift";
			8'd4:    return "fwd";
			8'd5:    return "mem";
			8'd6:    return "branch";
			8'd7:    return "hold";
			8'd8:    return "nop";
			8'd9:    return "random";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_field(input string test, input string field,
			input logic [word_w-1:0] exp_v, input logic [word_w-1:0] act_v);
		checks++;
		assert (act_v === exp_v) else begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", test, field, exp_v, act_v);
		end
	endtask

	////////////////////////////////////////
	// Compare one result slot
	////////////////////////////////////////
	task automatic check_slot(input expect_t e);
		string t;
		t = test_name(e.name);
		check_field(t, "out_valid", e.valid, out_valid);
		check_field(t, "reg_we", e.reg_we, reg_we);
		check_field(t, "mem_read", e.mem_read, mem_read);
		check_field(t, "mem_write", e.mem_write, mem_write);
		check_field(t, "br_taken", e.br_taken, br_taken);
		if (e.reg_we) begin
			check_field(t, "reg_addr", e.reg_addr, reg_addr);
			check_field(t, "reg_value", e.reg_value, reg_value);
		end
		if (e.mem_read || e.mem_write) begin
			check_field(t, "mem_addr", e.mem_addr, mem_addr);
		end
		if (e.mem_write) begin
			check_field(t, "mem_wdata", e.mem_wdata, mem_wdata);
		end
		if (e.br_taken) begin
			check_field(t, "br_target", e.br_target, br_target);
		end
		checks++;
		assert (!(mem_read && mem_write)) else begin
			errors++;
			$display("Load and store strobes were high together in test %s", t);
		end
	endtask

	// Drives one word per clock and checks the slot of the word two clocks older
	task automatic apply_cycle(input logic h, input logic v,
			input logic [word_w-1:0] w, input logic [word_w-1:0] p, input expect_t e);
		@(posedge clk);
		hold     <= h;
		in_valid <= v;
		instr    <= w;
		pc       <= p;
		exp_q.push_back(e);
		@(negedge clk);
		if (exp_q.size() > 2) begin
			check_slot(exp_q.pop_front());
		end
	endtask

	initial begin
		expect_t           e;
		int                base;
		logic              h;
		logic              v;
		logic [word_w-1:0] w;
		logic [31:0]       seed;
		logic [reg_aw-1:0] dst;
		int                init_cnt;
		logic              need_word;

		rst_n    = 1'b0;
		in_valid = 1'b0;
		hold     = 1'b0;
		instr    = nop_word;
		pc       = '0;
		$readmemh("sim/exe_input.txt", vec_mem);
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_slot('0);  // Everything quiet after reset

		////////////////////////////////////////
		// Directed vectors
		////////////////////////////////////////
		for (int i = 0; i < n_vec; i++) begin
			base        = i * n_col;
			h           = vec_mem[base+1][0];
			v           = vec_mem[base+2][0];
			e           = '0;
			e.name      = vec_mem[base][7:0];
			e.valid     = v && !h;  // Dropped words leave a bubble
			e.reg_we    = vec_mem[base+5][0];
			e.reg_addr  = vec_mem[base+6][reg_aw-1:0];
			e.reg_value = vec_mem[base+7];
			e.mem_read  = vec_mem[base+8][0];
			e.mem_write = vec_mem[base+9][0];
			e.mem_addr  = vec_mem[base+10];
			e.mem_wdata = vec_mem[base+11];
			e.br_taken  = vec_mem[base+12][0];
			e.br_target = vec_mem[base+13];
			apply_cycle(h, v, vec_mem[base+3], vec_mem[base+4], e);
		end

		////////////////////////////////////////
		// Random LI/ADDU stream under random hold
		////////////////////////////////////////
		seed      = 32'h2a5f;
		init_cnt  = 0;
		need_word = 1'b1;
		w         = nop_word;
		for (int k = 0; k < rand_n; k++) begin
			if (need_word) begin
				seed = next_rand(seed);
				if (init_cnt < reg_num) begin
					w = {op_li, init_cnt[reg_aw-1:0], seed[15:8]};  // Load every register first
				end else if (seed[0]) begin
					w = {op_li, seed[10:8], seed[23:16]};
				end else begin
					w = {op_rrr, seed[10:8], seed[13:11], seed[16:14], fn_addu};
				end
			end
			seed   = next_rand(seed);
			h      = (seed[2:0] < 3'd2);
			e      = '0;
			e.name = 8'd9;
			if (!h) begin
				if (w[15:11] == op_li) begin
					dst        = w[10:8];
					model[dst] = {8'h00, w[7:0]};
				end else begin
					dst        = w[4:2];
					model[dst] = model[w[10:8]] + model[w[7:5]];  // rz = rx + ry
				end
				e.valid     = 1'b1;
				e.reg_we    = 1'b1;
				e.reg_addr  = dst;
				e.reg_value = model[dst];
				if (init_cnt < reg_num) begin
					init_cnt++;
				end
			end
			need_word = !h;  // Held word is presented again
			apply_cycle(h, 1'b1, w, 16'h0100 + k[15:0], e);
		end

		// Drain the two stages
		repeat (2) apply_cycle(1'b0, 1'b0, nop_word, '0, '0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/alu_exe.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exe import cpu16_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire id_ex_t       stage,
	output logic [word_w-1:0] result,
	output ex_wb_t            wb
);

	logic [3:0] shamt;   // Decoder limits this to 1..8
	logic       mem_op;
	logic       taken;

	assign shamt  = stage.op2[3:0];
	assign mem_op = stage.mem_read || stage.mem_write;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (stage.alu_op)
			alu_add: result = stage.op1 + stage.op2;  // Also load/store address
			alu_sub: result = stage.op1 - stage.op2;
			alu_and: result = stage.op1 & stage.op2;
			alu_or:  result = stage.op1 | stage.op2;
			alu_cmp: result = {{(word_w-1){1'b0}}, stage.op1 != stage.op2};
			alu_sll: result = stage.op1 << shamt;
			alu_sra: result = $signed(stage.op1) >>> shamt;  // Keeps sign
			alu_srl: result = stage.op1 >> shamt;
			default: result = stage.op1;
		endcase
	end

	// Branch condition on op1
	always_comb begin
		case (stage.br_kind)
			br_always: taken = 1'b1;
			br_eqz:    taken = (stage.op1 == '0);
			br_nez:    taken = (stage.op1 != '0);
			default:   taken = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// Result register
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.valid     <= stage.valid;
			wb.reg_write <= stage.valid && stage.reg_write && !mem_op;
			wb.dest      <= stage.dest;
			wb.value     <= result;
			wb.mem_read  <= stage.valid && stage.mem_read;
			wb.mem_write <= stage.valid && stage.mem_write;
			wb.mem_addr  <= mem_op ? result : '0;
			wb.mem_wdata <= stage.store_value;
			wb.br_taken  <= stage.valid && taken;
			wb.br_target <= stage.br_target;
		end
	end

	// A bubble in execute never even evaluates as a taken branch
	a_no_branch_on_bubble: assert property (
		@(posedge clk) disable iff (!rst_n)
		!stage.valid |-> !taken
	) else $error("alu_exe: branch taken by invalid entry");

endmodule

`default_nettype wire

/* src/cpu16_pkg.sv */
`default_nettype none

package cpu16_pkg;

	localparam int word_w  = 16;
	localparam int reg_num = 8;
	localparam int reg_aw  = 3;

	localparam logic [word_w-1:0] nop_word = 16'h0800;

	////////////////////////////////////////
	// Major opcodes, bits 15:11
	////////////////////////////////////////
	localparam logic [4:0] op_nop   = 5'b00001;
	localparam logic [4:0] op_b     = 5'b00010;
	localparam logic [4:0] op_beqz  = 5'b00100;
	localparam logic [4:0] op_bnez  = 5'b00101;
	localparam logic [4:0] op_shift = 5'b00110;  // SLL, SRL, SRA
	localparam logic [4:0] op_addiu = 5'b01001;
	localparam logic [4:0] op_li    = 5'b01101;
	localparam logic [4:0] op_move  = 5'b01111;
	localparam logic [4:0] op_lw    = 5'b10011;
	localparam logic [4:0] op_sw    = 5'b11011;
	localparam logic [4:0] op_rrr   = 5'b11100;  // ADDU, SUBU
	localparam logic [4:0] op_logic = 5'b11101;  // AND, OR, CMP

	// Sub-function codes
	localparam logic [1:0] fn_addu  = 2'b01;
	localparam logic [1:0] fn_subu  = 2'b11;
	localparam logic [1:0] fn_sll   = 2'b00;
	localparam logic [1:0] fn_srl   = 2'b10;
	localparam logic [1:0] fn_sra   = 2'b11;
	localparam logic [4:0] fn5_and  = 5'b01100;
	localparam logic [4:0] fn5_or   = 5'b01101;
	localparam logic [4:0] fn5_cmp  = 5'b01010;
	localparam logic [4:0] fn5_move = 5'b00000;

	typedef struct packed {
		logic [4:0]        opcode;
		logic [reg_aw-1:0] rx;
		logic [7:0]        imm8;
	} instr_rri_t;

	typedef struct packed {
		logic [4:0]        opcode;
		logic [reg_aw-1:0] rx;
		logic [reg_aw-1:0] ry;
		union packed {
			logic [reg_aw-1:0] rz;
			logic [2:0]        shamt;  // Shifts, zero means eight
		} z;
		logic [1:0]        funct;
	} instr_rrr_t;

	typedef union packed {
		instr_rri_t rri;
		instr_rrr_t rrr;
	} instr_u;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_cmp,
		alu_sll, alu_sra, alu_srl, alu_pass
	} alu_op_e;

	typedef enum logic [1:0] {br_none, br_always, br_eqz, br_nez} br_kind_e;

	typedef struct packed {
		logic              valid;
		alu_op_e           alu_op;
		logic [word_w-1:0] op1;
		logic [word_w-1:0] op2;
		logic [word_w-1:0] store_value;
		logic [reg_aw-1:0] dest;
		logic              reg_write;
		logic              mem_read;
		logic              mem_write;
		br_kind_e          br_kind;
		logic [word_w-1:0] br_target;
	} id_ex_t;

	typedef struct packed {
		logic              valid;
		logic              reg_write;
		logic [reg_aw-1:0] dest;
		logic [word_w-1:0] value;
		logic              mem_read;
		logic              mem_write;
		logic [word_w-1:0] mem_addr;
		logic [word_w-1:0] mem_wdata;
		logic              br_taken;
		logic [word_w-1:0] br_target;
	} ex_wb_t;

endpackage

`default_nettype wire

/* src/exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_core import cpu16_pkg::*; (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_valid,
	input  wire                hold,
	input  wire [word_w-1:0]   instr,
	input  wire [word_w-1:0]   pc,
	output logic               out_valid,
	output logic               reg_we,
	output logic [reg_aw-1:0]  reg_addr,
	output logic [word_w-1:0]  reg_value,
	output logic               mem_read,
	output logic               mem_write,
	output logic [word_w-1:0]  mem_addr,
	output logic [word_w-1:0]  mem_wdata,
	output logic               br_taken,
	output logic [word_w-1:0]  br_target
);

	id_ex_t            ex_stage;
	ex_wb_t            wb;
	logic [reg_aw-1:0] src_a;
	logic [reg_aw-1:0] src_b;
	logic [word_w-1:0] rf_a;
	logic [word_w-1:0] rf_b;
	logic [word_w-1:0] opnd_a;
	logic [word_w-1:0] opnd_b;
	logic [word_w-1:0] ex_result;  // Combinational ALU output

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n),
		.raddr_a(src_a), .raddr_b(src_b),
		.rdata_a(rf_a), .rdata_b(rf_b),
		.wb(wb)
	);

	fwd_unit u_fwd_unit (
		.src_a(src_a), .src_b(src_b),
		.rf_a(rf_a), .rf_b(rf_b),
		.ex_stage(ex_stage), .ex_result(ex_result),
		.wb_stage(wb),
		.opnd_a(opnd_a), .opnd_b(opnd_b)
	);

	id_exe u_id_exe (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .hold(hold),
		.instr(instr_u'(instr)), .pc(pc),
		.src_a(src_a), .src_b(src_b),
		.opnd_a(opnd_a), .opnd_b(opnd_b),
		.stage(ex_stage)
	);

	alu_exe u_alu_exe (
		.clk(clk), .rst_n(rst_n),
		.stage(ex_stage), .result(ex_result), .wb(wb)
	);

	// Outputs straight from the result register
	assign out_valid = wb.valid;
	assign reg_we    = wb.reg_write;
	assign reg_addr  = wb.dest;
	assign reg_value = wb.value;
	assign mem_read  = wb.mem_read;
	assign mem_write = wb.mem_write;
	assign mem_addr  = wb.mem_addr;
	assign mem_wdata = wb.mem_wdata;
	assign br_taken  = wb.br_taken;
	assign br_target = wb.br_target;

endmodule

`default_nettype wire

/* src/fwd_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_unit import cpu16_pkg::*; (
	input  wire [reg_aw-1:0]  src_a,
	input  wire [reg_aw-1:0]  src_b,
	input  wire [word_w-1:0]  rf_a,
	input  wire [word_w-1:0]  rf_b,
	input  wire id_ex_t       ex_stage,
	input  wire [word_w-1:0]  ex_result,
	input  wire ex_wb_t       wb_stage,
	output logic [word_w-1:0] opnd_a,
	output logic [word_w-1:0] opnd_b
);

	logic ex_wr;  // Instruction in execute writes a register
	logic wb_wr;  // Instruction in result stage writes a register

	assign ex_wr = ex_stage.valid && ex_stage.reg_write;
	assign wb_wr = wb_stage.valid && wb_stage.reg_write;

	// Youngest producer wins
	// Result stage value is not yet in the array
	assign opnd_a = (ex_wr && ex_stage.dest == src_a) ? ex_result :
		(wb_wr && wb_stage.dest == src_a) ? wb_stage.value : rf_a;
	assign opnd_b = (ex_wr && ex_stage.dest == src_b) ? ex_result :
		(wb_wr && wb_stage.dest == src_b) ? wb_stage.value : rf_b;

endmodule

`default_nettype wire

/* src/id_exe.sv */
`timescale 1ns/1ps
`default_nettype none

module id_exe import cpu16_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    in_valid,
	input  wire                    hold,
	input  wire instr_u            instr,
	input  wire [word_w-1:0]       pc,
	output logic [reg_aw-1:0]      src_a,
	output logic [reg_aw-1:0]      src_b,
	input  wire [word_w-1:0]       opnd_a,
	input  wire [word_w-1:0]       opnd_b,
	output id_ex_t                 stage
);

	logic              take;  // Word accepted at this edge
	instr_u            word;  // Word actually decoded
	logic [4:0]        fn5;
	logic [word_w-1:0] pc_next;
	id_ex_t            dec;

	assign take    = in_valid && !hold;
	assign word    = take ? instr : instr_u'(nop_word);  // Bubble decodes as NOP
	assign fn5     = {word.rrr.z.rz, word.rrr.funct};
	assign pc_next = pc + 16'd1;

	// Shifts and MOVE read ry through port a
	always_comb begin
		case (word.rri.opcode)
			op_shift, op_move: src_a = word.rrr.ry;
			default:           src_a = word.rri.rx;
		endcase
	end

	assign src_b = word.rrr.ry;  // Second ALU source or store data

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////
	always_comb begin
		dec         = '0;
		dec.valid   = take;
		dec.alu_op  = alu_pass;
		dec.br_kind = br_none;
		case (word.rri.opcode)
			op_addiu: begin
				dec.alu_op    = alu_add;
				dec.op1       = opnd_a;
				dec.op2       = {{8{word.rri.imm8[7]}}, word.rri.imm8};
				dec.dest      = word.rri.rx;
				dec.reg_write = 1'b1;
			end
			op_li: begin
				dec.op1       = {8'b0, word.rri.imm8};  // Zero extended
				dec.dest      = word.rri.rx;
				dec.reg_write = 1'b1;
			end
			op_rrr: begin
				case (word.rrr.funct)
					fn_addu: dec.alu_op = alu_add;
					fn_subu: dec.alu_op = alu_sub;
					default: dec.alu_op = alu_pass;
				endcase
				if (dec.alu_op != alu_pass) begin
					dec.op1       = opnd_a;
					dec.op2       = opnd_b;
					dec.dest      = word.rrr.z.rz;
					dec.reg_write = 1'b1;
				end
			end
			op_logic: begin
				case (fn5)
					fn5_and: dec.alu_op = alu_and;
					fn5_or:  dec.alu_op = alu_or;
					fn5_cmp: dec.alu_op = alu_cmp;
					default: dec.alu_op = alu_pass;
				endcase
				if (dec.alu_op != alu_pass) begin
					dec.op1       = opnd_a;
					dec.op2       = opnd_b;
					dec.dest      = word.rrr.rx;  // CMP result lands in rx
					dec.reg_write = 1'b1;
				end
			end
			op_shift: begin
				case (word.rrr.funct)
					fn_sll:  dec.alu_op = alu_sll;
					fn_sra:  dec.alu_op = alu_sra;
					fn_srl:  dec.alu_op = alu_srl;
					default: dec.alu_op = alu_pass;
				endcase
				if (dec.alu_op != alu_pass) begin
					dec.op1       = opnd_a;
					dec.op2       = (word.rrr.z.shamt == 3'd0) ? 16'd8 :
						{13'b0, word.rrr.z.shamt};
					dec.dest      = word.rrr.rx;
					dec.reg_write = 1'b1;
				end
			end
			op_move: begin
				if (fn5 == fn5_move) begin
					dec.op1       = opnd_a;
					dec.dest      = word.rrr.rx;
					dec.reg_write = 1'b1;
				end
			end
			op_lw, op_sw: begin
				dec.alu_op      = alu_add;
				dec.op1         = opnd_a;  // Base rx
				dec.op2         = {{11{fn5[4]}}, fn5};
				dec.mem_read    = (word.rri.opcode == op_lw);
				dec.mem_write   = (word.rri.opcode == op_sw);
				dec.store_value = opnd_b;
			end
			op_b: begin
				dec.br_kind   = br_always;
				dec.br_target = pc_next + {{5{word.rri.rx[2]}}, word.rri.rx, word.rri.imm8};
			end
			op_beqz, op_bnez: begin
				dec.br_kind   = (word.rri.opcode == op_beqz) ? br_eqz : br_nez;
				dec.op1       = opnd_a;  // Tested against zero
				dec.br_target = pc_next + {{8{word.rri.imm8[7]}}, word.rri.imm8};
			end
			op_nop:  dec.alu_op = alu_pass;
			default: dec.alu_op = alu_pass;  // Unsupported words run as NOP
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage <= '0;
		end else begin
			stage <= dec;
		end
	end

	a_mem_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(stage.mem_read && stage.mem_write)
	) else $error("id_exe: load and store strobes together");

	// A dropped word leaves an inert bubble behind
	a_bubble_quiet: assert property (
		@(posedge clk) disable iff (!rst_n)
		!stage.valid |-> !stage.reg_write
	) else $error("id_exe: bubble carries a register write");

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu16_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire [reg_aw-1:0]       raddr_a,
	input  wire [reg_aw-1:0]       raddr_b,
	output logic [word_w-1:0]      rdata_a,
	output logic [word_w-1:0]      rdata_b,
	input  wire ex_wb_t            wb
);

	logic [word_w-1:0] regs [reg_num];
	logic              we;

	assign we = wb.valid && wb.reg_write;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_num; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wb.dest] <= wb.value;  // Result stage writes back
		end
	end

	// Plain array reads, no bypass here
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	// Write address must be resolved whenever a write is requested
	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		we |-> !$isunknown(wb.dest)
	) else $error("reg_file: write with unknown address");

endmodule

`default_nettype wire
